//--- test/program.hex
// one 64-bit doubleword per line, index 0 to 15
// low 32 bits hold the instruction at pc bit 2 clear
0010009300000013
0020811300308193
0041021300510293
0061831300718393
fedcba9876543210
8081828384858687
7f6e5d4c3b2a1908
00000093ffffffff
0000406380000000
c0ffee00deadbeef
123456789abcdef0
0ff0f00f8008ff80
a5a5a5a55a5a5a5a
0000000100008001
fffe00017fff8000
13579bdf2468ace0

//--- fetch.f
verilog/fetch_pkg.sv
verilog/mem_bus_if.sv
verilog/pc_gen.sv
verilog/fetch_stage.sv
verilog/load_unit.sv
verilog/mem_arbiter.sv
verilog/unified_mem.sv
verilog/fetch_top.sv
test/fetch_props.sv
test/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -f fetch.f --top-module fetch_tb -o Vfetch_tb

# program.hex is opened from the working directory
# the error limit lets the testbench reach its own verdict
(cd test && ../obj_dir/Vfetch_tb +verilator+error+limit+1000) 2>&1 | tee sim.log

if grep -q "^Simulation PASSED$" sim.log; then
	exit 0
else
	exit 1
fi

//--- test/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb
	import fetch_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int RST_CYCLES = 8;
	// tests take about 1200 cycles plus margin
	localparam int TIMEOUT_CYCLES = 2000;

	logic       clk;
	logic       cnt_rst;
	logic       redirect;
	addr_t      redirect_pc;
	logic       inst_ready;
	logic       inst_valid;
	inst_t      inst;
	addr_t      inst_pc;
	logic       load_req;
	addr_t      load_addr;
	load_size_e load_size;
	logic       load_signed;
	logic       load_busy;
	logic       load_valid;
	dword_t     load_data;

	logic [31:0] rng;
	int          cycles = 0;
	int          accepted = 0;
	int          loads_done = 0;
	int          check_errs = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          mark;
	int          base;

	fetch_top dut_i (
		.clk         (clk),
		.cnt_rst     (cnt_rst),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.inst_ready  (inst_ready),
		.inst_valid  (inst_valid),
		.inst        (inst),
		.inst_pc     (inst_pc),
		.load_req    (load_req),
		.load_addr   (load_addr),
		.load_size   (load_size),
		.load_signed (load_signed),
		.load_busy   (load_busy),
		.load_valid  (load_valid),
		.load_data   (load_data)
	);

	bind fetch_top fetch_props props_i (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation FAILED");
			$finish;
		end
	end

	// transfers counted mid-cycle away from the edges
	always @(negedge clk) begin
		if (!cnt_rst && inst_valid && inst_ready) begin
			accepted++;
		end
		if (!cnt_rst && load_valid) begin
			loads_done++;
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic int failures();
		return dut_i.props_i.fail_cnt + check_errs;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic expect_low(input string name, input logic value);
		if (value !== 1'b0) begin
			$display("FAILED at %0t: %s expected 0, got %b", $time, name, value);
			check_errs++;
		end
	endtask

	task automatic report_problem(input string what);
		$display("ERROR at %0t: %s", $time, what);
		check_errs++;
	endtask

	task automatic check_reset_outputs();
		expect_low("inst_valid", inst_valid);
		expect_low("load_valid", load_valid);
		expect_low("load_busy", load_busy);
	endtask

	task automatic start_test();
		mark = failures();
		tests_run++;
	endtask

	task automatic end_test(input string name);
		int n;
		n = failures() - mark;
		if (n != 0) begin
			tests_failed++;
		end
		$display("test %-12s %s, %0d failures", name, (n == 0) ? "ok" : "failed", n);
	endtask

	// one load with a bounded wait for its data
	task automatic issue_load(input int sz, input logic sgn, input addr_t addr);
		int waited;
		load_req    = 1'b1;
		load_size   = load_size_e'(sz);
		load_signed = sgn;
		load_addr   = addr;
		next_cycle();
		load_req = 1'b0;
		waited = 0;
		while (!load_valid && waited < 8) begin
			next_cycle();
			waited++;
		end
		if (!load_valid) begin
			report_problem("load did not return data");
		end
	endtask

	// naturally aligned address inside the memory
	function automatic addr_t aligned_addr(input logic [31:0] r, input int sz);
		return addr_t'(r[6:0]) & ~((addr_t'(1) << sz) - addr_t'(1));
	endfunction

	initial begin
		cnt_rst     = 1'b1;
		redirect    = 1'b0;
		redirect_pc = '0;
		inst_ready  = 1'b0;
		load_req    = 1'b0;
		load_addr   = '0;
		load_size   = LS_BYTE;
		load_signed = 1'b0;
		rng         = 32'd76255;

		start_test();
		for (int i = 0; i < RST_CYCLES; i++) begin
			next_cycle();
			check_reset_outputs();
		end
		cnt_rst = 1'b0;
		next_cycle();
		check_reset_outputs();
		end_test("reset_state");

		start_test();
		inst_ready = 1'b1;
		base = accepted;
		repeat (100) next_cycle();
		if (accepted - base < 40) begin
			report_problem("sequential fetch delivered too few instructions");
		end
		end_test("sequential");

		start_test();
		base = accepted;
		for (int i = 0; i < 300; i++) begin
			rng = xorshift32(rng);
			inst_ready = rng[0] & rng[3];
			next_cycle();
		end
		inst_ready = 1'b1;
		if (accepted - base < 30) begin
			report_problem("fetch stalled under back-pressure");
		end
		end_test("backpressure");

		start_test();
		for (int i = 0; i < 8; i++) begin
			int waited;
			rng = xorshift32(rng);
			repeat (3 + rng[1:0]) next_cycle();
			redirect    = 1'b1;
			redirect_pc = addr_t'({rng[11:4], 2'b00});
			next_cycle();
			redirect = 1'b0;
			base = accepted;
			waited = 0;
			while (accepted == base && waited < 10) begin
				next_cycle();
				waited++;
			end
			if (accepted == base) begin
				report_problem("no instruction arrived after a redirect");
			end
			repeat (10) next_cycle();
		end
		end_test("redirect");

		start_test();
		for (int sz = 0; sz < 4; sz++) begin
			for (int sgn = 0; sgn < 2; sgn++) begin
				for (int k = 0; k < 4; k++) begin
					rng = xorshift32(rng);
					issue_load(sz, sgn[0], aligned_addr(rng, sz));
				end
			end
		end
		end_test("loads");

		start_test();
		base = loads_done;
		for (int i = 0; i < 300; i++) begin
			rng = xorshift32(rng);
			if (!load_busy && rng[1:0] == 2'b00) begin
				load_req    = 1'b1;
				load_size   = load_size_e'(rng[9:8]);
				load_signed = rng[10];
				load_addr   = aligned_addr(xorshift32(rng), int'(rng[9:8]));
			end else begin
				load_req = 1'b0;
			end
			next_cycle();
		end
		load_req = 1'b0;
		repeat (4) next_cycle();
		if (loads_done - base < 10) begin
			report_problem("too few loads completed during contention");
		end
		end_test("contention");

		$display("summary: %0d tests, %0d failed, %0d assertion failures, %0d check errors",
			tests_run, tests_failed, dut_i.props_i.fail_cnt, check_errs);
		if (tests_failed == 0 && failures() == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

//--- test/fetch_props.sv
`timescale 1ns/1ns

module fetch_props
	import fetch_pkg::*;
(
	input logic       clk,
	input logic       cnt_rst,
	input logic       redirect,
	input addr_t      redirect_pc,
	input logic       inst_ready,
	input logic       inst_valid,
	input inst_t      inst,
	input addr_t      inst_pc,
	input logic       load_req,
	input addr_t      load_addr,
	input load_size_e load_size,
	input logic       load_signed,
	input logic       load_busy,
	input logic       load_valid,
	input dword_t     load_data
);

	// reference copy of the memory image
	dword_t prog [MEM_DEPTH];
	addr_t  exp_pc;
	int     fail_cnt = 0;

	initial begin
		$readmemh("program.hex", prog);
	end

	// 32-bit half picked by pc bit 2
	function automatic inst_t file_inst(input addr_t pc);
		dword_t word;
		word = prog[mem_idx_t'(pc >> 3)];
		return pc[2] ? word[63:32] : word[31:0];
	endfunction

	function automatic dword_t file_load(input addr_t addr, input load_size_e size,
			input logic sgn);
		dword_t word;
		dword_t field;
		word  = prog[mem_idx_t'(addr >> 3)];
		field = word >> (8 * addr[2:0]);
		case (size)
			LS_BYTE:
				return sgn ? dword_t'($signed(field[7:0])) : dword_t'(field[7:0]);
			LS_HALF:
				return sgn ? dword_t'($signed(field[15:0])) : dword_t'(field[15:0]);
			LS_WORD:
				return sgn ? dword_t'($signed(field[31:0])) : dword_t'(field[31:0]);
			default:
				return field;
		endcase
	endfunction

	// pc that the next presented instruction must carry
	always_ff @(posedge clk) begin
		if (cnt_rst) begin
			exp_pc <= RESET_PC;
		end else if (redirect) begin
			exp_pc <= redirect_pc;
		end else if (inst_valid && inst_ready) begin
			exp_pc <= exp_pc + addr_t'(4);
		end
	end

	inst_matches_file: assert property (@(posedge clk) disable iff (cnt_rst)
		inst_valid |-> inst == file_inst(exp_pc))
	else begin
		fail_cnt++;
		$error("FAILED at %0t: inst expected %h, got %h", $time,
			file_inst($sampled(exp_pc)), $sampled(inst));
	end

	pc_in_order: assert property (@(posedge clk) disable iff (cnt_rst)
		inst_valid |-> inst_pc == exp_pc)
	else begin
		fail_cnt++;
		$error("FAILED at %0t: inst_pc expected %h, got %h", $time,
			$sampled(exp_pc), $sampled(inst_pc));
	end

	// held instruction must not move while decode stalls
	inst_held: assert property (@(posedge clk) disable iff (cnt_rst)
		inst_valid && $past(inst_valid && !inst_ready) |->
			inst == $past(inst) && inst_pc == $past(inst_pc))
	else begin
		fail_cnt++;
		$error("FAILED at %0t: inst_pc expected %h, got %h, inst expected %h, got %h",
			$time, $past(inst_pc), $sampled(inst_pc), $past(inst), $sampled(inst));
	end

	load_latency: assert property (@(posedge clk) disable iff (cnt_rst)
		load_valid == $past(load_req && !load_busy, 2))
	else begin
		fail_cnt++;
		$error("FAILED at %0t: load_valid expected %b, got %b", $time,
			$past(load_req && !load_busy, 2), $sampled(load_valid));
	end

	load_value: assert property (@(posedge clk) disable iff (cnt_rst)
		load_valid |-> load_data ==
			file_load($past(load_addr, 2), $past(load_size, 2), $past(load_signed, 2)))
	else begin
		fail_cnt++;
		$error("FAILED at %0t: load_data expected %h, got %h", $time,
			file_load($past(load_addr, 2), $past(load_size, 2), $past(load_signed, 2)),
			$sampled(load_data));
	end

endmodule

//--- verilog/fetch_top.sv
`timescale 1ns/1ns

module fetch_top
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       cnt_rst,
	input  logic       redirect,
	input  addr_t      redirect_pc,
	input  logic       inst_ready,
	output logic       inst_valid,
	output inst_t      inst,
	output addr_t      inst_pc,
	input  logic       load_req,
	input  addr_t      load_addr,
	input  load_size_e load_size,
	input  logic       load_signed,
	output logic       load_busy,
	output logic       load_valid,
	output dword_t     load_data
);

	addr_t    pc;
	logic     advance;
	logic     rd_en;
	mem_idx_t rd_idx;
	dword_t   rd_data;

	// one read channel per requester
	mem_bus_if fetch_bus ();
	mem_bus_if load_bus ();

	pc_gen pc_gen_i (
		.clk         (clk),
		.cnt_rst     (cnt_rst),
		.advance     (advance),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.pc          (pc)
	);

	fetch_stage fetch_stage_i (
		.clk        (clk),
		.cnt_rst    (cnt_rst),
		.bus        (fetch_bus.requester),
		.pc         (pc),
		.advance    (advance),
		.redirect   (redirect),
		.inst_valid (inst_valid),
		.inst_ready (inst_ready),
		.inst       (inst),
		.inst_pc    (inst_pc)
	);

	load_unit load_unit_i (
		.clk         (clk),
		.cnt_rst     (cnt_rst),
		.bus         (load_bus.requester),
		.load_req    (load_req),
		.load_addr   (load_addr),
		.load_size   (load_size),
		.load_signed (load_signed),
		.load_busy   (load_busy),
		.load_valid  (load_valid),
		.load_data   (load_data)
	);

	mem_arbiter mem_arbiter_i (
		.clk       (clk),
		.cnt_rst   (cnt_rst),
		.fetch_bus (fetch_bus.arbiter),
		.load_bus  (load_bus.arbiter),
		.rd_en     (rd_en),
		.rd_idx    (rd_idx),
		.rd_data   (rd_data)
	);

	unified_mem unified_mem_i (
		.clk     (clk),
		.rd_en   (rd_en),
		.rd_idx  (rd_idx),
		.rd_data (rd_data)
	);

endmodule

//--- verilog/unified_mem.sv
`timescale 1ns/1ns

module unified_mem
	import fetch_pkg::*;
(
	input  logic     clk,
	input  logic     rd_en,
	input  mem_idx_t rd_idx,
	output dword_t   rd_data
);

	// instructions and data share one array
	dword_t mem [MEM_DEPTH];

	initial begin
		$readmemh("program.hex", mem);
	end

	// registered read, data one cycle after rd_en
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_idx];
		end
	end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter
	import fetch_pkg::*;
(
	input  logic       clk,
	input  logic       cnt_rst,
	mem_bus_if.arbiter fetch_bus,
	mem_bus_if.arbiter load_bus,
	output logic       rd_en,
	output mem_idx_t   rd_idx,
	input  dword_t     rd_data
);

	arb_state_e owner_d;
	arb_state_e owner_q;
	addr_t      sel_addr;

	// load unit first, fetch takes the port otherwise
	always_comb begin
		load_bus.gnt  = load_bus.req;
		fetch_bus.gnt = fetch_bus.req && !load_bus.req;
		if (load_bus.req) begin
			owner_d  = ARB_LOAD;
			sel_addr = load_bus.addr;
		end else if (fetch_bus.req) begin
			owner_d  = ARB_FETCH;
			sel_addr = fetch_bus.addr;
		end else begin
			owner_d  = ARB_NONE;
			sel_addr = fetch_bus.addr;
		end
	end

	// byte address to doubleword index
	assign rd_en  = (owner_d != ARB_NONE);
	assign rd_idx = sel_addr[MEM_IDX_W+2:3];

	always_ff @(posedge clk) begin
		if (cnt_rst) begin
			owner_q <= ARB_NONE;
		end else begin
			owner_q <= owner_d;
		end
	end

	// response goes back to last cycle's owner only
	assign load_bus.rvalid  = (owner_q == ARB_LOAD);
	assign fetch_bus.rvalid = (owner_q == ARB_FETCH);
	assign load_bus.rdata   = rd_data;
	assign fetch_bus.rdata  = rd_data;

endmodule

//--- verilog/load_unit.sv
`timescale 1ns/1ns

module load_unit
	import fetch_pkg::*;
(
	input  logic         clk,
	input  logic         cnt_rst,
	mem_bus_if.requester bus,
	input  logic         load_req,
	input  addr_t        load_addr,
	input  load_size_e   load_size,
	input  logic         load_signed,
	output logic         load_busy,
	output logic         load_valid,
	output dword_t       load_data
);

	logic       busy_q;
	logic       issued_q;
	logic       accept;
	logic       done;
	addr_t      addr_q;
	load_size_e size_q;
	logic       signed_q;
	logic       valid_q;
	dword_t     data_q;
	dword_t     shifted;
	dword_t     ext_data;

	assign accept = load_req && !busy_q;
	assign done   = busy_q && issued_q && bus.rvalid;

	// new request goes out directly, a refused one is retried from addr_q
	assign bus.req  = accept || (busy_q && !issued_q);
	assign bus.addr = busy_q ? addr_q : load_addr;

	// addressed field down to bit zero
	assign shifted = bus.rdata >> {addr_q[2:0], 3'b000};

	always_comb begin
		case (size_q)
			LS_BYTE:
				ext_data = {{56{signed_q & shifted[7]}}, shifted[7:0]};
			LS_HALF:
				ext_data = {{48{signed_q & shifted[15]}}, shifted[15:0]};
			LS_WORD:
				ext_data = {{32{signed_q & shifted[31]}}, shifted[31:0]};
			default:
				ext_data = shifted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (cnt_rst) begin
			busy_q   <= 1'b0;
			issued_q <= 1'b0;
			valid_q  <= 1'b0;
		end else begin
			valid_q <= done;
			if (accept) begin
				busy_q   <= 1'b1;
				issued_q <= bus.gnt;
			end else if (done) begin
				busy_q   <= 1'b0;
				issued_q <= 1'b0;
			end else if (busy_q && bus.gnt) begin
				issued_q <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q   <= load_addr;
			size_q   <= load_size;
			signed_q <= load_signed;
		end
		if (done) begin
			data_q <= ext_data;
		end
	end

	assign load_busy  = busy_q;
	assign load_valid = valid_q;
	assign load_data  = data_q;

endmodule

//--- verilog/fetch_stage.sv
`timescale 1ns/1ns

module fetch_stage
	import fetch_pkg::*;
(
	input  logic         clk,
	input  logic         cnt_rst,
	mem_bus_if.requester bus,
	input  addr_t        pc,
	output logic         advance,
	input  logic         redirect,
	output logic         inst_valid,
	input  logic         inst_ready,
	output inst_t        inst,
	output addr_t        inst_pc
);

	logic             accept;
	logic             push;
	logic             pop;
	logic [CNT_W:0]   pending;
	logic [CNT_W-1:0] inflight_cnt;
	logic [CNT_W-1:0] squash_cnt;
	logic [CNT_W-1:0] buf_cnt;

	// addresses of outstanding reads, oldest at aq_rd
	addr_t            addr_q [MAX_INFLIGHT];
	logic [PTR_W-1:0] aq_wr;
	logic [PTR_W-1:0] aq_rd;

	// instruction buffer toward decode
	inst_t            buf_inst [MAX_INFLIGHT];
	addr_t            buf_pc [MAX_INFLIGHT];
	logic [PTR_W-1:0] buf_wr;
	logic [PTR_W-1:0] buf_rd;

	addr_t            resp_pc;
	inst_t            resp_inst;

	// a slot freed by this cycle's pop counts as room
	assign pending = {1'b0, inflight_cnt} + {1'b0, buf_cnt} - (CNT_W + 1)'(pop);

	// no new read in a redirect cycle, pc is stale there
	assign bus.req  = (pending < (CNT_W + 1)'(MAX_INFLIGHT)) && !redirect;
	assign bus.addr = pc;
	assign accept   = bus.req && bus.gnt;
	assign advance  = accept;

	// upper word when address bit 2 is set
	assign resp_pc   = addr_q[aq_rd];
	assign resp_inst = resp_pc[2] ? bus.rdata[63:32] : bus.rdata[31:0];

	assign push = bus.rvalid && !redirect && (squash_cnt == '0);
	assign pop  = inst_valid && inst_ready;

	// pending instruction is dropped on redirect
	assign inst_valid = (buf_cnt != '0) && !redirect;
	assign inst       = buf_inst[buf_rd];
	assign inst_pc    = buf_pc[buf_rd];

	always_ff @(posedge clk) begin
		if (cnt_rst) begin
			inflight_cnt <= '0;
			squash_cnt   <= '0;
			aq_wr        <= '0;
			aq_rd        <= '0;
			buf_wr       <= '0;
			buf_rd       <= '0;
			buf_cnt      <= '0;
		end else begin
			inflight_cnt <= inflight_cnt + CNT_W'(accept) - CNT_W'(bus.rvalid);
			if (accept) begin
				aq_wr <= aq_wr + PTR_W'(1);
			end
			if (bus.rvalid) begin
				aq_rd <= aq_rd + PTR_W'(1);
			end
			if (redirect) begin
				// every read still out after this cycle is stale
				squash_cnt <= inflight_cnt - CNT_W'(bus.rvalid);
				buf_wr     <= '0;
				buf_rd     <= '0;
				buf_cnt    <= '0;
			end else begin
				if (bus.rvalid && squash_cnt != '0) begin
					squash_cnt <= squash_cnt - CNT_W'(1);
				end
				if (push) begin
					buf_wr <= buf_wr + PTR_W'(1);
				end
				if (pop) begin
					buf_rd <= buf_rd + PTR_W'(1);
				end
				buf_cnt <= buf_cnt + CNT_W'(push) - CNT_W'(pop);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			addr_q[aq_wr] <= pc;
		end
		if (push) begin
			buf_inst[buf_wr] <= resp_inst;
			buf_pc[buf_wr]   <= resp_pc;
		end
	end

endmodule

//--- verilog/pc_gen.sv
`timescale 1ns/1ns

module pc_gen
	import fetch_pkg::*;
(
	input  logic  clk,
	input  logic  cnt_rst,
	input  logic  advance,
	input  logic  redirect,
	input  addr_t redirect_pc,
	output addr_t pc
);

	addr_t pc_q;
	addr_t pc_seq;
	addr_t pc_next;

	// next sequential instruction
	assign pc_seq = pc_q + addr_t'(4);

	// redirect target beats the sequential step
	always_comb begin
		if (redirect) begin
			pc_next = redirect_pc;
		end else if (advance) begin
			pc_next = pc_seq;
		end else begin
			pc_next = pc_q;
		end
	end

	always_ff @(posedge clk) begin
		if (cnt_rst) begin
			pc_q <= RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc = pc_q;

endmodule

//--- verilog/mem_bus_if.sv
`timescale 1ns/1ns

interface mem_bus_if
	import fetch_pkg::*;
();

	// request side
	logic   req;
	addr_t  addr;
	logic   gnt;

	// response, one cycle after req and gnt
	logic   rvalid;
	dword_t rdata;

	modport requester (
		output req,
		output addr,
		input  gnt,
		input  rvalid,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  addr,
		output gnt,
		output rvalid,
		output rdata
	);

endinterface

//--- verilog/fetch_pkg.sv
package fetch_pkg;

	// memory geometry, one entry per doubleword
	localparam int MEM_DEPTH = 16;
	localparam int MEM_IDX_W = $clog2(MEM_DEPTH);

	// fetch reads plus buffered instructions allowed at once
	localparam int MAX_INFLIGHT = 2;

	// counter and pointer widths for the fetch tracking
	localparam int CNT_W = $clog2(MAX_INFLIGHT + 1);
	localparam int PTR_W = $clog2(MAX_INFLIGHT);

	// byte address
	typedef logic [63:0] addr_t;

	// one instruction word
	typedef logic [31:0] inst_t;

	// memory data, one doubleword
	typedef logic [63:0] dword_t;

	// doubleword index into the memory
	typedef logic [MEM_IDX_W-1:0] mem_idx_t;

	// first fetch address after reset
	localparam addr_t RESET_PC = 64'h0;

	// access width of a load
	typedef enum logic [1:0] {
		LS_BYTE,
		LS_HALF,
		LS_WORD,
		LS_DOUBLE
	} load_size_e;

	// owner of the previous cycle's grant
	typedef enum logic [1:0] {
		ARB_NONE,
		ARB_FETCH,
		ARB_LOAD
	} arb_state_e;

endpackage
